/* logic/cci_checker_params.svh */
////////////////////////////////////////////////////////////
// CCI request checker constants: request and length codes,
// error codes, log depth, MMIO timeout and APB register map
////////////////////////////////////////////////////////////
`ifndef CCI_CHECKER_PARAMS_SVH
`define CCI_CHECKER_PARAMS_SVH

// CCI-P request types
`define REQ_WRLINE_I 4'h1
`define REQ_WRLINE_M 4'h2
`define REQ_RDLINE_S 4'h4
`define REQ_WRFENCE  4'h5
`define REQ_RDLINE_I 4'h6

// Cache-line length codes
`define LEN_1CL 2'd0
`define LEN_2CL 2'd1
`define LEN_3CL 2'd2
`define LEN_4CL 2'd3

// Error codes, lowest wins inside one checker
`define ERR_C0_BAD_REQ       4'd1
`define ERR_C0_LEN3          4'd2
`define ERR_C0_ALIGN         4'd3
`define ERR_C1_BAD_REQ       4'd4
`define ERR_C1_LEN3          4'd5
`define ERR_C1_ALIGN         4'd6
`define ERR_C1_SOP           4'd7
`define ERR_C1_ADDR_SEQ      4'd8
`define ERR_C1_VC            4'd9
`define ERR_MMIO_TIMEOUT     4'd10
`define ERR_MMIO_UNSOLICITED 4'd11
`define ERR_MMIO_TID         4'd12

// Error record payload width
`define ERR_INFO_W 24

// Log and MMIO limits
`define LOG_DEPTH    16
`define MMIO_TIMEOUT 512
`define MMIO_CNT_W   10

// APB register map, one word per log entry
`define REG_COUNT    12'h000
`define REG_CLEAR    12'h008
`define REG_LOG_BASE 12'h040
// Keeps page bits and byte lane of a log access
`define REG_LOG_MASK 12'hFC3

`endif

/* logic/cci_checker_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the CCI request checker
////////////////////////////////////////////////////////////
package cci_checker_pkg;

   // Cache-line address and request header fields
   typedef logic [31:0] cl_addr_t;
   typedef logic [3:0]  req_type_t;
   typedef logic [1:0]  cl_len_t;
   typedef logic [1:0]  vc_t;

   // MMIO transaction id
   typedef logic [8:0]  tid_t;

   // Error log
   typedef logic [3:0]  err_code_t;
   // Code in 31:24, low address or tid in 23:0
   typedef logic [31:0] log_entry_t;
   typedef logic [3:0]  log_idx_t;
   // Holds 0 to 16
   typedef logic [4:0]  log_cnt_t;

   // Multi-line write beat tracking, encoding equals beat index
   typedef enum logic [1:0] {
      EXPECT_FIRST,
      EXPECT_BEAT2,
      EXPECT_BEAT3,
      EXPECT_BEAT4
   } beat_state_e;

   typedef enum logic {
      MMIO_IDLE,
      MMIO_WAIT
   } mmio_state_e;

endpackage

/* logic/cci_checker_ifs.sv */
////////////////////////////////////////////////////////////
// Error report handshake and log read interfaces
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

// One pending error record, held until granted
interface err_report_if
   import cci_checker_pkg::*;
();
   logic                   req;
   err_code_t              code;
   logic [`ERR_INFO_W-1:0] info;
   logic                   gnt;

   modport reporter (output req, code, info, input gnt);
   modport arbiter  (input req, code, info, output gnt);
endinterface

// Register block view of the error log
interface log_read_if
   import cci_checker_pkg::*;
();
   log_idx_t   rd_idx;
   logic       clear;
   log_entry_t rd_data;
   log_cnt_t   count;

   modport regs (output rd_idx, clear, input rd_data, count);
   modport log  (input rd_idx, clear, output rd_data, count);
endinterface

/* logic/c0_read_checker.sv */
////////////////////////////////////////////////////////////
// C0Tx read request checker: type, length and alignment
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module c0_read_checker
   import cci_checker_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           c0tx_valid,
   input  req_type_t      c0tx_reqtype,
   input  cl_len_t        c0tx_len,
   input  cl_addr_t       c0tx_addr,
   err_report_if.reporter rpt
);

   logic      bad_req;
   logic      len3_err;
   logic      align_err;
   logic      err_hit;
   logic      capture;
   err_code_t err_code;

   // Only the two read types are legal on C0
   assign bad_req = c0tx_valid &&
      !(c0tx_reqtype == `REQ_RDLINE_S || c0tx_reqtype == `REQ_RDLINE_I);
   assign len3_err = c0tx_valid && c0tx_len == `LEN_3CL;
   // 2-line needs even address, 4-line needs 4-line boundary
   assign align_err = c0tx_valid &&
      ((c0tx_len == `LEN_2CL && c0tx_addr[0]) ||
       (c0tx_len == `LEN_4CL && c0tx_addr[1:0] != 2'b00));
   assign err_hit = bad_req || len3_err || align_err;

   // Lowest code first
   assign err_code = bad_req  ? `ERR_C0_BAD_REQ :
                     len3_err ? `ERR_C0_LEN3    : `ERR_C0_ALIGN;

   // New record only when slot is free or being granted now
   assign capture = err_hit && (!rpt.req || rpt.gnt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rpt.req <= 1'b0;
      end else if (capture) begin
         rpt.req <= 1'b1;
      end else if (rpt.gnt) begin
         rpt.req <= 1'b0;
      end
   end

   // Record payload
   always_ff @(posedge clk) begin
      if (capture) begin
         rpt.code <= err_code;
         rpt.info <= c0tx_addr[`ERR_INFO_W-1:0];
      end
   end

endmodule

/* logic/c1_write_checker.sv */
////////////////////////////////////////////////////////////
// C1Tx write checker: multi-line beat FSM with sop,
// address sequence and vc checks, one pending record
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module c1_write_checker
   import cci_checker_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           c1tx_valid,
   input  req_type_t      c1tx_reqtype,
   input  cl_len_t        c1tx_len,
   input  logic           c1tx_sop,
   input  vc_t            c1tx_vc,
   input  cl_addr_t       c1tx_addr,
   err_report_if.reporter rpt
);

   beat_state_e state;
   beat_state_e state_nxt;
   cl_addr_t    base_addr;
   vc_t         base_vc;
   cl_len_t     base_len;
   cl_addr_t    exp_addr;
   logic        wrline;
   logic        first;
   logic        multi_line;
   logic        bad_req;
   logic        len3_err;
   logic        align_err;
   logic        sop_err;
   logic        addr_err;
   logic        vc_err;
   logic        err_hit;
   logic        capture;
   err_code_t   err_code;

   assign wrline = c1tx_valid &&
      (c1tx_reqtype == `REQ_WRLINE_I || c1tx_reqtype == `REQ_WRLINE_M);
   // Fence is the only legal non-data request
   assign bad_req    = c1tx_valid && !wrline && c1tx_reqtype != `REQ_WRFENCE;
   assign first      = state == EXPECT_FIRST;
   assign multi_line = c1tx_len == `LEN_2CL || c1tx_len == `LEN_4CL;

   // Beat index is the state encoding
   assign exp_addr = base_addr + cl_addr_t'(state);

   // First beat checks
   assign len3_err  = wrline && first && c1tx_len == `LEN_3CL;
   assign align_err = wrline && first &&
      ((c1tx_len == `LEN_2CL && c1tx_addr[0]) ||
       (c1tx_len == `LEN_4CL && c1tx_addr[1:0] != 2'b00));

   // sop high on first beat only
   assign sop_err = wrline && (first ? !c1tx_sop : c1tx_sop);

   // Later beats follow base address and keep the vc
   assign addr_err = wrline && !first && c1tx_addr != exp_addr;
   assign vc_err   = wrline && !first && c1tx_vc != base_vc;

   assign err_hit = bad_req || len3_err || align_err || sop_err || addr_err || vc_err;

   // Lowest failing code
   always_comb begin
      if (bad_req)
         err_code = `ERR_C1_BAD_REQ;
      else if (len3_err)
         err_code = `ERR_C1_LEN3;
      else if (align_err)
         err_code = `ERR_C1_ALIGN;
      else if (sop_err)
         err_code = `ERR_C1_SOP;
      else if (addr_err)
         err_code = `ERR_C1_ADDR_SEQ;
      else
         err_code = `ERR_C1_VC;
   end

   // Advances on every write line, errors or not
   always_comb begin
      state_nxt = state;
      if (wrline) begin
         case (state)
            EXPECT_FIRST: state_nxt = multi_line ? EXPECT_BEAT2 : EXPECT_FIRST;
            EXPECT_BEAT2: state_nxt = (base_len == `LEN_4CL) ? EXPECT_BEAT3 : EXPECT_FIRST;
            EXPECT_BEAT3: state_nxt = EXPECT_BEAT4;
            default:      state_nxt = EXPECT_FIRST;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= EXPECT_FIRST;
      end else begin
         state <= state_nxt;
      end
   end

   // Header of a multi-line write
   always_ff @(posedge clk) begin
      if (wrline && first && multi_line) begin
         base_addr <= c1tx_addr;
         base_vc   <= c1tx_vc;
         base_len  <= c1tx_len;
      end
   end

   // Pending record slot
   assign capture = err_hit && (!rpt.req || rpt.gnt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rpt.req <= 1'b0;
      end else if (capture) begin
         rpt.req <= 1'b1;
      end else if (rpt.gnt) begin
         rpt.req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         rpt.code <= err_code;
         rpt.info <= c1tx_addr[`ERR_INFO_W-1:0];
      end
   end

endmodule

/* logic/mmio_read_tracker.sv */
////////////////////////////////////////////////////////////
// MMIO read tracker: timeout, unsolicited response and
// tid mismatch, one pending record
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module mmio_read_tracker
   import cci_checker_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           mmio_rd_req_valid,
   input  tid_t           mmio_rd_req_tid,
   input  logic           mmio_rd_rsp_valid,
   input  tid_t           mmio_rd_rsp_tid,
   err_report_if.reporter rpt
);

   mmio_state_e           state;
   tid_t                  req_tid;
   logic [`MMIO_CNT_W-1:0] wait_cnt;
   logic                  waiting;
   logic                  timeout;
   logic                  unsolicited;
   logic                  tid_err;
   logic                  capture;
   err_code_t             err_code;
   tid_t                  err_tid;

   assign waiting = state == MMIO_WAIT;
   // Response in the same cycle beats the timeout
   assign timeout     = waiting && !mmio_rd_rsp_valid &&
                        wait_cnt == `MMIO_CNT_W'(`MMIO_TIMEOUT - 1);
   assign unsolicited = !waiting && mmio_rd_rsp_valid;
   assign tid_err     = waiting && mmio_rd_rsp_valid && mmio_rd_rsp_tid != req_tid;

   assign err_code = timeout     ? `ERR_MMIO_TIMEOUT :
                     unsolicited ? `ERR_MMIO_UNSOLICITED : `ERR_MMIO_TID;
   // Timeout reports the stored tid, the others the response tid
   assign err_tid  = timeout ? req_tid : mmio_rd_rsp_tid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= MMIO_IDLE;
         wait_cnt <= '0;
      end else if (!waiting) begin
         wait_cnt <= '0;
         if (mmio_rd_req_valid)
            state <= MMIO_WAIT;
      end else if (mmio_rd_rsp_valid || timeout) begin
         state <= MMIO_IDLE;
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // Only one outstanding read is tracked
   always_ff @(posedge clk) begin
      if (!waiting && mmio_rd_req_valid)
         req_tid <= mmio_rd_req_tid;
   end

   assign capture = (timeout || unsolicited || tid_err) && (!rpt.req || rpt.gnt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rpt.req <= 1'b0;
      end else if (capture) begin
         rpt.req <= 1'b1;
      end else if (rpt.gnt) begin
         rpt.req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         rpt.code <= err_code;
         rpt.info <= `ERR_INFO_W'(err_tid);
      end
   end

endmodule

/* logic/err_log_arbiter.sv */
////////////////////////////////////////////////////////////
// Round-robin arbiter over three error reporters, error log
// memory, entry count and irq
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module err_log_arbiter
   import cci_checker_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   err_report_if.arbiter c0_rpt,
   err_report_if.arbiter c1_rpt,
   err_report_if.arbiter mmio_rpt,
   log_read_if.log       rd,
   output logic          irq
);

   log_entry_t             log_mem [`LOG_DEPTH];
   log_cnt_t               count;
   logic [2:0]             req_vec;
   logic [2:0]             gnt_vec;
   logic [1:0]             last_gnt;
   logic [1:0]             gnt_idx;
   logic [1:0]             slot;
   err_code_t              win_code;
   logic [`ERR_INFO_W-1:0] win_info;
   logic                   log_full;

   assign req_vec = {mmio_rpt.req, c1_rpt.req, c0_rpt.req};

   // Search starts at the requester after the last grant
   always_comb begin
      gnt_vec = 3'b000;
      gnt_idx = 2'd0;
      slot    = last_gnt;
      for (int i = 0; i < 3; i++) begin
         slot = (slot == 2'd2) ? 2'd0 : slot + 2'd1;
         if (gnt_vec == 3'b000 && req_vec[slot]) begin
            gnt_vec[slot] = 1'b1;
            gnt_idx       = slot;
         end
      end
   end

   assign c0_rpt.gnt   = gnt_vec[0];
   assign c1_rpt.gnt   = gnt_vec[1];
   assign mmio_rpt.gnt = gnt_vec[2];

   // Winning record
   always_comb begin
      case (gnt_idx)
         2'd1: begin
            win_code = c1_rpt.code;
            win_info = c1_rpt.info;
         end
         2'd2: begin
            win_code = mmio_rpt.code;
            win_info = mmio_rpt.info;
         end
         default: begin
            win_code = c0_rpt.code;
            win_info = c0_rpt.info;
         end
      endcase
   end

   // Grants go on when full, record is dropped
   assign log_full = count == log_cnt_t'(`LOG_DEPTH);

   always_ff @(posedge clk) begin
      if (|gnt_vec && !log_full && !rd.clear)
         log_mem[log_idx_t'(count)] <= {4'h0, win_code, win_info};
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count    <= '0;
         last_gnt <= 2'd2;
         irq      <= 1'b0;
      end else begin
         if (rd.clear)
            count <= '0;
         else if (|gnt_vec && !log_full)
            count <= count + 1'b1;
         if (|gnt_vec)
            last_gnt <= gnt_idx;
         // One cycle behind count
         irq <= count != '0;
      end
   end

   assign rd.count   = count;
   assign rd.rd_data = log_mem[rd.rd_idx];

endmodule

/* logic/apb_log_regs.sv */
////////////////////////////////////////////////////////////
// APB slave for the error log: count, entries, clear
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module apb_log_regs
   import cci_checker_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [11:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   log_read_if.regs    rd
);

   logic rd_access;
   logic wr_access;
   logic is_count;
   logic is_clear;
   logic is_log;
   logic log_hit;

   // Zero wait states, access phase completes at once
   assign pready    = 1'b1;
   assign rd_access = psel && penable && !pwrite;
   assign wr_access = psel && penable && pwrite;

   // Address decode
   assign is_count = paddr == `REG_COUNT;
   assign is_clear = paddr == `REG_CLEAR;
   assign is_log   = (paddr & `REG_LOG_MASK) == `REG_LOG_BASE;
   assign rd.rd_idx = paddr[5:2];
   // Slots at or past count read as errors
   assign log_hit  = is_log && {1'b0, rd.rd_idx} < rd.count;

   always_comb begin
      if (rd_access && is_count)
         prdata = 32'(rd.count);
      else if (rd_access && log_hit)
         prdata = rd.rd_data;
      else
         prdata = '0;
   end

   assign pslverr = (rd_access && !is_count && !log_hit) || (wr_access && !is_clear);

   // Any non-zero write to REG_CLEAR, one cycle strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd.clear <= 1'b0;
      end else begin
         rd.clear <= wr_access && is_clear && |pwdata;
      end
   end

endmodule

/* logic/cci_checker_top.sv */
////////////////////////////////////////////////////////////
// CCI request checker top: C0, C1 and MMIO checkers,
// error log arbiter and APB register block
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cci_checker_top
   import cci_checker_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // C0Tx reads
   input  logic        c0tx_valid,
   input  req_type_t   c0tx_reqtype,
   input  cl_len_t     c0tx_len,
   input  cl_addr_t    c0tx_addr,
   // C1Tx writes
   input  logic        c1tx_valid,
   input  req_type_t   c1tx_reqtype,
   input  cl_len_t     c1tx_len,
   input  logic        c1tx_sop,
   input  vc_t         c1tx_vc,
   input  cl_addr_t    c1tx_addr,
   // MMIO read request and response
   input  logic        mmio_rd_req_valid,
   input  tid_t        mmio_rd_req_tid,
   input  logic        mmio_rd_rsp_valid,
   input  tid_t        mmio_rd_rsp_tid,
   // APB
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [11:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        irq
);

   err_report_if c0_rpt_if ();
   err_report_if c1_rpt_if ();
   err_report_if mmio_rpt_if ();
   log_read_if   log_rd_if ();

   c0_read_checker c0_read_checker_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .c0tx_valid   (c0tx_valid),
      .c0tx_reqtype (c0tx_reqtype),
      .c0tx_len     (c0tx_len),
      .c0tx_addr    (c0tx_addr),
      .rpt          (c0_rpt_if.reporter)
   );

   c1_write_checker c1_write_checker_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .c1tx_valid   (c1tx_valid),
      .c1tx_reqtype (c1tx_reqtype),
      .c1tx_len     (c1tx_len),
      .c1tx_sop     (c1tx_sop),
      .c1tx_vc      (c1tx_vc),
      .c1tx_addr    (c1tx_addr),
      .rpt          (c1_rpt_if.reporter)
   );

   mmio_read_tracker mmio_read_tracker_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .mmio_rd_req_valid (mmio_rd_req_valid),
      .mmio_rd_req_tid   (mmio_rd_req_tid),
      .mmio_rd_rsp_valid (mmio_rd_rsp_valid),
      .mmio_rd_rsp_tid   (mmio_rd_rsp_tid),
      .rpt               (mmio_rpt_if.reporter)
   );

   // Shared log, one record per cycle
   err_log_arbiter err_log_arbiter_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .c0_rpt   (c0_rpt_if.arbiter),
      .c1_rpt   (c1_rpt_if.arbiter),
      .mmio_rpt (mmio_rpt_if.arbiter),
      .rd       (log_rd_if.log),
      .irq      (irq)
   );

   apb_log_regs apb_log_regs_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .rd      (log_rd_if.regs)
   );

endmodule

/* tests/clk_gen.sv */
////////////////////////////////////////////////////////////
// Testbench clock at 4 ns and reset held for 5 cycles
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Release on a rising edge like any other driven input
   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* tests/cci_checker_tb.sv */
////////////////////////////////////////////////////////////
// Testbench of the CCI checker with traffic and APB tasks
// and log checks for read, write, MMIO, arbitration and clear
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cci_checker_params.svh"

module cci_checker_tb
   import cci_checker_pkg::*;
();

   logic        clk;
   logic        rst_n;
   logic        c0tx_valid;
   req_type_t   c0tx_reqtype;
   cl_len_t     c0tx_len;
   cl_addr_t    c0tx_addr;
   logic        c1tx_valid;
   req_type_t   c1tx_reqtype;
   cl_len_t     c1tx_len;
   logic        c1tx_sop;
   vc_t         c1tx_vc;
   cl_addr_t    c1tx_addr;
   logic        mmio_rd_req_valid;
   tid_t        mmio_rd_req_tid;
   logic        mmio_rd_rsp_valid;
   tid_t        mmio_rd_rsp_tid;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        irq;

   int unsigned cycle_cnt = 0;
   int          exp_count;

   clk_gen clk_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   cci_checker_top cci_checker_top_inst (.*);

   // Free running cycle count for wait limits
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else report_mismatch(name, exp, act);
   endtask

   // Log word with code in 31:24 and address or tid below
   function automatic logic [31:0] log_word(input err_code_t code, input logic [23:0] info);
      return {4'h0, code, info};
   endfunction

   function automatic cl_len_t legal_len(input int unsigned pick);
      case (pick % 3)
         0: return `LEN_1CL;
         1: return `LEN_2CL;
         default: return `LEN_4CL;
      endcase
   endfunction

   // APB read with setup then access phase
   task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                           output logic err);
      int n;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!pready && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (!pready)
         stop_run("APB read got no pready");
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                            output logic err);
      int n;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!pready && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (!pready)
         stop_run("APB write got no pready");
      err = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // Poll the count register until it equals target
   task automatic wait_count(input int target, input int unsigned limit);
      int unsigned start;
      logic [31:0] data;
      logic        err;
      logic        done;
      start = cycle_cnt;
      done  = 1'b0;
      while (!done) begin
         read_reg(`REG_COUNT, data, err);
         if (data == 32'(target))
            done = 1'b1;
         else if (cycle_cnt - start > limit)
            stop_run($sformatf("timeout: log count stuck at %0d, wanted %0d", data, target));
      end
   endtask

   task automatic wait_irq(input logic level, input int unsigned limit);
      int unsigned n;
      n = 0;
      @(negedge clk);
      while (irq !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (irq !== level)
         stop_run($sformatf("timeout: irq never went to %0b", level));
   endtask

   task automatic check_count(input string name, input int exp);
      logic [31:0] data;
      logic        err;
      read_reg(`REG_COUNT, data, err);
      check_equal(name, 32'(exp), data);
      check_equal({name, " pslverr"}, 32'h0, {31'h0, err});
   endtask

   task automatic check_irq(input string name, input logic level);
      @(negedge clk);
      check_equal(name, {31'h0, level}, {31'h0, irq});
   endtask

   task automatic check_entry(input string name, input int idx, input logic [31:0] exp);
      logic [31:0] data;
      logic        err;
      read_reg(`REG_LOG_BASE + 12'(idx * 4), data, err);
      check_equal(name, exp, data);
      check_equal({name, " pslverr"}, 32'h0, {31'h0, err});
   endtask

   // One new entry appended at the tail of the log
   task automatic expect_logged(input string name, input err_code_t code,
                                input logic [23:0] info, input int unsigned limit);
      wait_count(exp_count + 1, limit);
      exp_count++;
      check_entry(name, exp_count - 1, log_word(code, info));
   endtask

   // Traffic drivers with one valid cycle each
   task automatic send_read(input req_type_t rtype, input cl_len_t len, input cl_addr_t addr);
      @(posedge clk);
      c0tx_valid   <= 1'b1;
      c0tx_reqtype <= rtype;
      c0tx_len     <= len;
      c0tx_addr    <= addr;
      @(posedge clk);
      c0tx_valid <= 1'b0;
   endtask

   task automatic send_write(input req_type_t rtype, input cl_len_t len, input logic sop,
                             input vc_t vc, input cl_addr_t addr);
      @(posedge clk);
      c1tx_valid   <= 1'b1;
      c1tx_reqtype <= rtype;
      c1tx_len     <= len;
      c1tx_sop     <= sop;
      c1tx_vc      <= vc;
      c1tx_addr    <= addr;
      @(posedge clk);
      c1tx_valid <= 1'b0;
   endtask

   // Well formed multi-line write
   task automatic send_burst(input cl_len_t len, input int beats, input vc_t vc,
                             input cl_addr_t base);
      for (int i = 0; i < beats; i++) begin
         send_write(`REQ_WRLINE_M, len, i == 0, vc, base + 32'(i));
      end
   endtask

   task automatic send_mmio_req(input tid_t tid);
      @(posedge clk);
      mmio_rd_req_valid <= 1'b1;
      mmio_rd_req_tid   <= tid;
      @(posedge clk);
      mmio_rd_req_valid <= 1'b0;
   endtask

   task automatic send_mmio_rsp(input tid_t tid);
      @(posedge clk);
      mmio_rd_rsp_valid <= 1'b1;
      mmio_rd_rsp_tid   <= tid;
      @(posedge clk);
      mmio_rd_rsp_valid <= 1'b0;
   endtask

   initial begin
      int unsigned n;
      cl_addr_t    addr;
      cl_addr_t    bad;
      tid_t        tid;
      logic [31:0] data;
      logic        err;
      logic [15:0] seen;

      void'($urandom(32'h3501));
      c0tx_valid        = 1'b0;
      c0tx_reqtype      = '0;
      c0tx_len          = '0;
      c0tx_addr         = '0;
      c1tx_valid        = 1'b0;
      c1tx_reqtype      = '0;
      c1tx_len          = '0;
      c1tx_sop          = 1'b0;
      c1tx_vc           = '0;
      c1tx_addr         = '0;
      mmio_rd_req_valid = 1'b0;
      mmio_rd_req_tid   = '0;
      mmio_rd_rsp_valid = 1'b0;
      mmio_rd_rsp_tid   = '0;
      psel              = 1'b0;
      penable           = 1'b0;
      pwrite            = 1'b0;
      paddr             = '0;
      pwdata            = '0;
      exp_count         = 0;

      n = 0;
      while (rst_n !== 1'b1 && n < 50) begin
         @(posedge clk);
         n++;
      end
      if (rst_n !== 1'b1)
         stop_run("reset was never released");
      check_count("reset count", 0);
      check_irq("reset irq", 1'b0);

      // Legal reads, writes, fence and answered MMIO read
      repeat (8) begin
         addr = $urandom & 32'hFFFF_FFFC;
         send_read(($urandom & 1) ? `REQ_RDLINE_S : `REQ_RDLINE_I, legal_len($urandom), addr);
      end
      send_write(`REQ_WRLINE_I, `LEN_1CL, 1'b1, vc_t'($urandom), $urandom);
      send_burst(`LEN_2CL, 2, vc_t'($urandom), $urandom & 32'hFFFF_FFFE);
      send_burst(`LEN_4CL, 4, vc_t'($urandom), $urandom & 32'hFFFF_FFFC);
      send_write(`REQ_WRFENCE, `LEN_1CL, 1'b0, 2'd0, 32'h0);
      tid = tid_t'($urandom);
      send_mmio_req(tid);
      repeat (3) @(posedge clk);
      send_mmio_rsp(tid);
      repeat (20) @(posedge clk);
      check_count("legal traffic count", 0);
      check_irq("legal traffic irq", 1'b0);

      // C0 checks one at a time
      addr = $urandom;
      send_read(`REQ_WRLINE_I, `LEN_1CL, addr);
      expect_logged("c0 bad request", `ERR_C0_BAD_REQ, addr[23:0], 20);
      wait_irq(1'b1, 10);
      addr = $urandom & 32'hFFFF_FFFC;
      send_read(`REQ_RDLINE_S, `LEN_3CL, addr);
      expect_logged("c0 length 3", `ERR_C0_LEN3, addr[23:0], 20);
      addr = ($urandom & 32'hFFFF_FFFC) | 32'h1;
      send_read(`REQ_RDLINE_I, `LEN_4CL, addr);
      expect_logged("c0 misaligned 4-line", `ERR_C0_ALIGN, addr[23:0], 20);

      // C1 beat sequence faults
      addr = $urandom & 32'hFFFF_FFFC;
      send_write(`REQ_WRLINE_I, `LEN_1CL, 1'b0, 2'd1, addr);
      expect_logged("c1 missing sop", `ERR_C1_SOP, addr[23:0], 20);
      addr = $urandom & 32'hFFFF_FFFE;
      bad  = addr + 32'd2;
      send_write(`REQ_WRLINE_M, `LEN_2CL, 1'b1, 2'd2, addr);
      send_write(`REQ_WRLINE_M, `LEN_2CL, 1'b0, 2'd2, bad);
      expect_logged("c1 address sequence", `ERR_C1_ADDR_SEQ, bad[23:0], 20);
      addr = $urandom & 32'hFFFF_FFFC;
      bad  = addr + 32'd2;
      send_write(`REQ_WRLINE_I, `LEN_4CL, 1'b1, 2'd0, addr);
      send_write(`REQ_WRLINE_I, `LEN_4CL, 1'b0, 2'd0, addr + 32'd1);
      send_write(`REQ_WRLINE_I, `LEN_4CL, 1'b0, 2'd3, bad);
      send_write(`REQ_WRLINE_I, `LEN_4CL, 1'b0, 2'd0, addr + 32'd3);
      expect_logged("c1 vc change", `ERR_C1_VC, bad[23:0], 20);

      // MMIO faults
      tid = tid_t'($urandom);
      send_mmio_rsp(tid);
      expect_logged("mmio unsolicited", `ERR_MMIO_UNSOLICITED, 24'(tid), 20);
      tid = tid_t'($urandom);
      send_mmio_req(tid);
      send_mmio_rsp(tid ^ 9'h1);
      expect_logged("mmio tid", `ERR_MMIO_TID, 24'(tid ^ 9'h1), 20);
      tid = tid_t'($urandom);
      send_mmio_req(tid);
      expect_logged("mmio timeout", `ERR_MMIO_TIMEOUT, 24'(tid), 600);

      // Three reporters in the same cycle
      @(posedge clk);
      c0tx_valid        <= 1'b1;
      c0tx_reqtype      <= `REQ_WRFENCE;
      c0tx_len          <= `LEN_1CL;
      c0tx_addr         <= $urandom;
      c1tx_valid        <= 1'b1;
      c1tx_reqtype      <= `REQ_RDLINE_S;
      c1tx_len          <= `LEN_1CL;
      c1tx_sop          <= 1'b1;
      c1tx_addr         <= $urandom;
      mmio_rd_rsp_valid <= 1'b1;
      mmio_rd_rsp_tid   <= tid_t'($urandom);
      @(posedge clk);
      c0tx_valid        <= 1'b0;
      c1tx_valid        <= 1'b0;
      mmio_rd_rsp_valid <= 1'b0;
      wait_count(exp_count + 3, 20);
      check_count("simultaneous count", exp_count + 3);
      // Grant order is free so codes compare as a set
      seen = '0;
      for (int i = 0; i < 3; i++) begin
         read_reg(`REG_LOG_BASE + 12'((exp_count + i) * 4), data, err);
         check_equal("simultaneous entry top bits", 32'h0, {28'h0, data[31:28]});
         seen[data[27:24]] = 1'b1;
      end
      check_equal("simultaneous code set",
                  {16'h0, (16'h1 << `ERR_C0_BAD_REQ) | (16'h1 << `ERR_C1_BAD_REQ) |
                          (16'h1 << `ERR_MMIO_UNSOLICITED)},
                  {16'h0, seen});
      exp_count += 3;

      // Six more errors of which only four fit
      bad = '0;
      for (int i = 0; i < 6; i++) begin
         addr = $urandom;
         if (i == 3)
            bad = addr;
         send_read(`REQ_WRFENCE, `LEN_1CL, addr);
      end
      wait_count(`LOG_DEPTH, 20);
      check_entry("last kept entry", `LOG_DEPTH - 1, log_word(`ERR_C0_BAD_REQ, bad[23:0]));
      check_count("saturated count", `LOG_DEPTH);

      // Clear then watch count and irq drop
      write_reg(`REG_CLEAR, 32'h1, err);
      check_equal("clear pslverr", 32'h0, {31'h0, err});
      wait_count(0, 20);
      wait_irq(1'b0, 10);
      exp_count = 0;

      // Error responses
      read_reg(`REG_LOG_BASE, data, err);
      check_equal("read past count data", 32'h0, data);
      check_equal("read past count pslverr", 32'h1, {31'h0, err});
      read_reg(12'h004, data, err);
      check_equal("unmapped read data", 32'h0, data);
      check_equal("unmapped read pslverr", 32'h1, {31'h0, err});
      write_reg(`REG_COUNT, 32'h5, err);
      check_equal("count write pslverr", 32'h1, {31'h0, err});
      check_count("final count", 0);

      $display("Verification passed");
      $finish;
   end

endmodule

/* cci_checker.f */
+incdir+logic
logic/cci_checker_pkg.sv
logic/cci_checker_ifs.sv
logic/c0_read_checker.sv
logic/c1_write_checker.sv
logic/mmio_read_tracker.sv
logic/err_log_arbiter.sv
logic/apb_log_regs.sv
logic/cci_checker_top.sv
tests/clk_gen.sv
tests/cci_checker_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f cci_checker.f --top-module cci_checker_tb \
   -Mdir obj_dir -o cci_checker_sim

output=$(./obj_dir/cci_checker_sim || true)
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
   exit 0
else
   exit 1
fi
